// File: src/mmio_cpl_pkg.sv
`default_nettype none

// Shared types and constants for the MMIO read completion path
// A host read request is remembered by tag until the register slave answers
// under the same tag, then both halves are merged into one completion
package mmio_cpl_pkg;

    // Tag space of the host read requests
    localparam int TAG_WIDTH = 5;

    // One table slot per possible tag
    localparam int MAX_OUTSTANDING_RD = 32;

    // Format and type byte of a completion with data, 3DW header
    localparam logic [7:0] CPL_FMTTYPE_CPLD = 8'h4a;

    // Host read request as seen on the request port
    // Only the details needed later to build the completion are carried
    typedef struct packed {
        logic [TAG_WIDTH-1:0] tag;
        // Requester ID is echoed back so the host can route the completion
        logic [15:0] requester_id;
        // Low address bits of the original read
        logic [6:0] lower_addr;
        // Read size in bytes, 4 or 8 for register reads
        logic [11:0] byte_count;
    } t_mmio_host_req;

    // Read data from the register slave
    typedef struct packed {
        // Tag copied from the request being answered
        logic [TAG_WIDTH-1:0] tag;
        logic [63:0] payload;
    } t_mmio_afu_rsp;

    // One response FIFO record
    // The response is stored together with the request details found for its tag
    typedef struct packed {
        t_mmio_afu_rsp rsp;
        t_mmio_host_req req;
    } t_mmio_rsp_entry;

    // Completion header fields
    typedef struct packed {
        logic [7:0] fmttype;
        // Length in dwords
        logic [9:0] length;
        // Remaining byte count, equal to the request size for a single completion
        logic [11:0] byte_count;
        logic [15:0] requester_id;
        logic [TAG_WIDTH-1:0] tag;
        logic [6:0] lower_addr;
    } t_mmio_cpl_hdr;

    // Completion record leaving the design
    typedef struct packed {
        t_mmio_cpl_hdr hdr;
        // Up to two dwords of read data
        logic [63:0] payload;
    } t_mmio_cpl;

endpackage

`default_nettype wire

// File: src/mmio_read_tracker.sv
`default_nettype none
`timescale 1ns/1ps

// Keeps the details of every outstanding host read by tag
// Responses look their request up combinationally through rsp.tag
// Also watches the tag protocol and raises a sticky error on misuse
module mmio_read_tracker
(
    input  logic clk,
    input  logic reset_n,

    // Host read requests are always accepted
    input  logic req_valid,
    input  mmio_cpl_pkg::t_mmio_host_req req,

    // Slave response and its transfer strobe
    input  mmio_cpl_pkg::t_mmio_afu_rsp rsp,
    input  logic rsp_fire,

    // Response joined with the request details for its tag
    output mmio_cpl_pkg::t_mmio_rsp_entry entry,

    output logic error
);

    import mmio_cpl_pkg::*;

    // Request held one cycle before it reaches the table
    logic req_valid_q;
    t_mmio_host_req req_q;

    // Request details indexed by tag
    t_mmio_host_req meta_table [MAX_OUTSTANDING_RD];

    // One bit per tag, set while a read is outstanding
    logic [MAX_OUTSTANDING_RD-1:0] tag_active;
    logic [MAX_OUTSTANDING_RD-1:0] tag_set;
    logic [MAX_OUTSTANDING_RD-1:0] tag_clr;

    logic tag_released;
    logic req_dup;
    logic rsp_orphan;

    // Valid bit of the registered request
    always_ff @(posedge clk)
    begin
        req_valid_q <= req_valid;

        if (!reset_n)
        begin
            req_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (req_valid)
        begin
            req_q <= req;
        end
    end

    // The table is written one edge after the request was seen,
    // so a response may use the tag from the edge after that
    always_ff @(posedge clk)
    begin
        if (req_valid_q)
        begin
            meta_table[req_q.tag] <= req_q;
        end
    end

    // Combinational lookup with the tag of the pending response
    assign entry.rsp = rsp;
    assign entry.req = meta_table[rsp.tag];

    // A tag freed by a response in this cycle may be reused by a new request
    assign tag_released = rsp_fire && (rsp.tag == req.tag);

    // Request for a tag that is still in use
    assign req_dup = req_valid && tag_active[req.tag] && !tag_released;

    // Response for a tag that has no read outstanding
    assign rsp_orphan = rsp_fire && !tag_active[rsp.tag];

    always_comb
    begin
        tag_set = '0;
        tag_clr = '0;

        if (req_valid)
        begin
            tag_set[req.tag] = 1'b1;
        end

        if (rsp_fire)
        begin
            tag_clr[rsp.tag] = 1'b1;
        end
    end

    // Set wins over clear so a same-cycle reuse leaves the tag active
    always_ff @(posedge clk)
    begin
        tag_active <= (tag_active & ~tag_clr) | tag_set;

        // Error stays set until the next reset
        if (req_dup || rsp_orphan)
        begin
            error <= 1'b1;
        end

        if (!reset_n)
        begin
            tag_active <= '0;
            error <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: src/mmio_rsp_fifo.sv
`default_nettype none
`timescale 1ns/1ps

// Circular buffer for joined response records
// The head is visible on first without a cycle of delay
module mmio_rsp_fifo
#(
    parameter int FIFO_DEPTH = 2
)
(
    input  logic clk,
    input  logic reset_n,

    // Write side
    input  logic enq_en,
    input  mmio_cpl_pkg::t_mmio_rsp_entry enq_data,
    output logic not_full,

    // Read side
    input  logic deq,
    output mmio_cpl_pkg::t_mmio_rsp_entry first,
    output logic not_empty
);

    import mmio_cpl_pkg::*;

    // A depth of one still needs a one bit pointer
    localparam int PTR_WIDTH = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

    // Count runs from zero up to FIFO_DEPTH inclusive
    localparam int CNT_WIDTH = $clog2(FIFO_DEPTH + 1);

    t_mmio_rsp_entry mem [FIFO_DEPTH];

    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic [CNT_WIDTH-1:0] count;

    logic do_enq;
    logic do_deq;

    // Pointer step with an explicit wrap for depths that are not powers of two
    function automatic logic [PTR_WIDTH-1:0] ptr_inc(input logic [PTR_WIDTH-1:0] ptr);
        if (ptr == PTR_WIDTH'(FIFO_DEPTH - 1))
        begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign not_full = (count != CNT_WIDTH'(FIFO_DEPTH));
    assign not_empty = (count != '0);

    // When full, a write is still taken if the head leaves in the same cycle
    assign do_deq = deq && not_empty;
    assign do_enq = enq_en && (not_full || do_deq);

    assign first = mem[rd_ptr];

    // Entries are written at the write pointer on every enqueue
    always_ff @(posedge clk)
    begin
        if (do_enq)
        begin
            mem[wr_ptr] <= enq_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (do_enq)
        begin
            wr_ptr <= ptr_inc(wr_ptr);
        end

        if (do_deq)
        begin
            rd_ptr <= ptr_inc(rd_ptr);
        end

        // Occupancy moves only when exactly one side is active
        case ({do_enq, do_deq})
            2'b10: count <= count + 1'b1;
            2'b01: count <= count - 1'b1;
            default: count <= count;
        endcase

        if (!reset_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
    end

endmodule

`default_nettype wire

// File: src/mmio_cpl_builder.sv
`default_nettype none
`timescale 1ns/1ps

// Turns the FIFO head into a completion and holds it in a registered
// valid/ready output stage
module mmio_cpl_builder
(
    input  logic clk,
    input  logic reset_n,

    // FIFO head and its handshake
    input  mmio_cpl_pkg::t_mmio_rsp_entry first,
    input  logic not_empty,
    output logic deq,

    // Completion stream
    output logic cpl_valid,
    output mmio_cpl_pkg::t_mmio_cpl cpl,
    input  logic cpl_ready
);

    import mmio_cpl_pkg::*;

    // Header built from the current FIFO head
    t_mmio_cpl_hdr cpl_hdr;

    // Output stage can take a new completion this cycle
    logic stage_load;

    always_comb
    begin
        cpl_hdr.fmttype = CPL_FMTTYPE_CPLD;

        // Byte count is a multiple of four, so dropping two bits gives dwords
        cpl_hdr.length = first.req.byte_count[11:2];

        // Request details recorded when the host read arrived
        cpl_hdr.byte_count = first.req.byte_count;
        cpl_hdr.requester_id = first.req.requester_id;
        cpl_hdr.lower_addr = first.req.lower_addr;

        // Tag comes from the slave response
        cpl_hdr.tag = first.rsp.tag;
    end

    // The stage is free when empty or when its completion leaves now
    assign stage_load = !cpl_valid || cpl_ready;

    // Head leaves the FIFO exactly when it moves into the stage
    assign deq = not_empty && stage_load;

    // Payload side of the stage, only written on a real load so the
    // completion holds still under back-pressure
    always_ff @(posedge clk)
    begin
        if (deq)
        begin
            cpl.hdr <= cpl_hdr;
            cpl.payload <= first.rsp.payload;
        end
    end

    // Valid of the stage
    always_ff @(posedge clk)
    begin
        if (stage_load)
        begin
            cpl_valid <= not_empty;
        end

        if (!reset_n)
        begin
            cpl_valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: src/mmio_cpl_top.sv
`default_nettype none
`timescale 1ns/1ps

// MMIO read completion generator
// Requests are tracked by tag, responses are joined with their request
// details and queued, and completions leave through a valid/ready stage
module mmio_cpl_top
#(
    parameter int FIFO_DEPTH = 2
)
(
    input  logic clk,
    input  logic reset_n,

    // Host read requests, no ready
    input  logic req_valid,
    input  mmio_cpl_pkg::t_mmio_host_req req,

    // Register slave responses
    input  logic rsp_valid,
    input  mmio_cpl_pkg::t_mmio_afu_rsp rsp,
    output logic rsp_ready,

    // Completions to the host
    output logic cpl_valid,
    output mmio_cpl_pkg::t_mmio_cpl cpl,
    input  logic cpl_ready,

    // Sticky tag protocol error
    output logic error
);

    import mmio_cpl_pkg::*;

    // Response accepted into the FIFO
    logic rsp_fire;

    // Record entering the FIFO and record at its head
    t_mmio_rsp_entry rsp_entry;
    t_mmio_rsp_entry fifo_first;

    logic fifo_not_empty;
    logic fifo_deq;

    // Back-pressure to the slave is the FIFO's free space
    assign rsp_fire = rsp_valid && rsp_ready;

    mmio_read_tracker tracker
    (
        .clk(clk),
        .reset_n(reset_n),
        .req_valid(req_valid),
        .req(req),
        .rsp(rsp),
        .rsp_fire(rsp_fire),
        .entry(rsp_entry),
        .error(error)
    );

    mmio_rsp_fifo
    #(
        .FIFO_DEPTH(FIFO_DEPTH)
    )
    rsp_fifo
    (
        .clk(clk),
        .reset_n(reset_n),
        .enq_en(rsp_fire),
        .enq_data(rsp_entry),
        .not_full(rsp_ready),
        .deq(fifo_deq),
        .first(fifo_first),
        .not_empty(fifo_not_empty)
    );

    mmio_cpl_builder builder
    (
        .clk(clk),
        .reset_n(reset_n),
        .first(fifo_first),
        .not_empty(fifo_not_empty),
        .deq(fifo_deq),
        .cpl_valid(cpl_valid),
        .cpl(cpl),
        .cpl_ready(cpl_ready)
    );

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
`default_nettype none
`timescale 1ns/1ps

// Clock and reset source for the testbench
// reset_n falls on a falling edge and stays low for RESET_CYCLES rising edges
module tb_clock_gen
#(
    parameter int HALF_PERIOD = 2,
    parameter int RESET_CYCLES = 5
)
(
    // A request sampled on the rising edge starts a new reset at the next falling edge
    input  logic reset_request,
    output logic clk,
    output logic reset_n
);

    logic restart = 1'b0;
    logic reset_q = 1'b0;
    int reset_left = RESET_CYCLES;

    initial clk = 1'b0;

    always #HALF_PERIOD clk = ~clk;

    always @(posedge clk)
    begin
        restart <= reset_request;
    end

    // Counting on falling edges keeps reset_n away from the DUT's sampling edge
    // A request that is still high once reset_n is low does not lengthen the reset
    always @(negedge clk)
    begin
        if (restart && reset_q)
        begin
            reset_q <= 1'b0;
            reset_left <= RESET_CYCLES;
        end
        else if (reset_left != 0)
        begin
            reset_left <= reset_left - 1;
            reset_q <= (reset_left == 1);
        end
    end

    assign reset_n = reset_q;

endmodule

`default_nettype wire

// File: testbench/tb_mmio_cpl.sv
`default_nettype none
`timescale 1ns/1ps

// Testbench for the MMIO read completion generator
// A model of the tag table predicts each completion, and a queue keeps
// them in the order their responses were accepted
module tb_mmio_cpl;

    import mmio_cpl_pkg::*;

    localparam int FIFO_DEPTH = 2;
    // Longest wait in cycles for a handshake, a drain or a reset edge
    localparam int WAIT_LIMIT = 200;

    logic clk;
    logic reset_n;
    logic reset_request;
    logic req_valid;
    t_mmio_host_req req;
    logic rsp_valid;
    t_mmio_afu_rsp rsp;
    logic rsp_ready;
    logic cpl_valid;
    t_mmio_cpl cpl;
    logic cpl_ready;
    logic error;

    // Reference model of the tag table, the active map and the error flag
    t_mmio_host_req model_table [MAX_OUTSTANDING_RD];
    logic [MAX_OUTSTANDING_RD-1:0] model_active;
    logic expect_error;
    t_mmio_cpl exp_q [$];

    // Completions waiting in the FIFO and whether the output stage holds one
    int model_fill;
    logic model_stage;

    // Completion that was stalled in the previous cycle
    logic held;
    t_mmio_cpl held_cpl;

    logic throttle;
    logic rsp_taken;
    integer seed;
    logic [TAG_WIDTH-1:0] tags [MAX_OUTSTANDING_RD];

    tb_clock_gen clock
    (
        .reset_request(reset_request),
        .clk(clk),
        .reset_n(reset_n)
    );

    mmio_cpl_top
    #(
        .FIFO_DEPTH(FIFO_DEPTH)
    )
    uut
    (
        .clk(clk),
        .reset_n(reset_n),
        .req_valid(req_valid),
        .req(req),
        .rsp_valid(rsp_valid),
        .rsp(rsp),
        .rsp_ready(rsp_ready),
        .cpl_valid(cpl_valid),
        .cpl(cpl),
        .cpl_ready(cpl_ready),
        .error(error)
    );

    task automatic report_mismatch(input string name, input logic [127:0] expected,
                                   input logic [127:0] actual);
        $display("TB FAILED");
        $display("FAIL at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
        $fatal(1);
    endtask

    task automatic report_problem(input string what);
        $display("TB FAILED");
        $display("At %0t: %s", $time, what);
        $fatal(1);
    endtask

    function automatic logic [31:0] next_random();
        return $random(seed);
    endfunction

    // Completion as the host should see it for a request and its response
    function automatic t_mmio_cpl make_expected_cpl(input t_mmio_host_req r,
                                                    input t_mmio_afu_rsp s);
        t_mmio_cpl c;
        c.hdr.fmttype = CPL_FMTTYPE_CPLD;
        c.hdr.length = 10'(r.byte_count / 4);
        c.hdr.byte_count = r.byte_count;
        c.hdr.requester_id = r.requester_id;
        c.hdr.tag = s.tag;
        c.hdr.lower_addr = r.lower_addr;
        c.payload = s.payload;
        return c;
    endfunction

    // Runs one clock cycle with the other inputs already set on this falling edge
    task automatic advance();
        logic [31:0] rnd;
        logic rsp_fire;
        logic stage_free;
        rnd = next_random();
        // A throttled consumer takes a completion in about one cycle of four
        cpl_ready = throttle ? (rnd[1:0] == 2'b00) : 1'b1;
        assert (cpl_valid == model_stage)
        else report_mismatch("cpl_valid", 128'(model_stage), 128'(cpl_valid));
        assert (rsp_ready == (model_fill < FIFO_DEPTH))
        else report_mismatch("rsp_ready", 128'(model_fill < FIFO_DEPTH), 128'(rsp_ready));
        if (model_stage)
        begin
            assert (cpl == exp_q[0])
            else report_mismatch("cpl", 128'(exp_q[0]), 128'(cpl));
            if (cpl_ready)
            begin
                void'(exp_q.pop_front());
            end
        end
        // The handshakes below happen on the coming rising edge
        // A free output stage takes the oldest completion waiting in the FIFO
        stage_free = !model_stage || cpl_ready;
        if (stage_free)
        begin
            model_stage = (model_fill != 0);
            if (model_fill != 0)
            begin
                model_fill--;
            end
        end
        rsp_fire = rsp_valid && rsp_ready;
        if (rsp_fire)
        begin
            expect_error = expect_error || !model_active[rsp.tag];
            exp_q.push_back(make_expected_cpl(model_table[rsp.tag], rsp));
            model_active[rsp.tag] = 1'b0;
            model_fill++;
        end
        // A tag freed in the same cycle may be reused, so the clear comes first
        if (req_valid)
        begin
            expect_error = expect_error || model_active[req.tag];
            model_active[req.tag] = 1'b1;
            model_table[req.tag] = req;
        end
        rsp_taken = rsp_fire;
        held = cpl_valid && !cpl_ready;
        held_cpl = cpl;
        @(negedge clk);
        assert (error == expect_error)
        else report_mismatch("error", 128'(expect_error), 128'(error));
        if (held)
        begin
            assert (cpl_valid)
            else report_mismatch("cpl_valid", 128'(1'b1), 128'(cpl_valid));
            assert (cpl == held_cpl)
            else report_mismatch("cpl", 128'(held_cpl), 128'(cpl));
        end
    endtask

    task automatic idle(input int cycles);
        req_valid = 1'b0;
        rsp_valid = 1'b0;
        repeat (cycles)
            advance();
    endtask

    task automatic send_req(input logic [TAG_WIDTH-1:0] tag);
        logic [31:0] rnd;
        rnd = next_random();
        req_valid = 1'b1;
        req.tag = tag;
        req.requester_id = rnd[15:0];
        req.lower_addr = rnd[22:16];
        // Register reads are one or two dwords
        req.byte_count = rnd[23] ? 12'd8 : 12'd4;
        advance();
        req_valid = 1'b0;
    endtask

    // Holds the response until the DUT takes it
    task automatic send_rsp(input logic [TAG_WIDTH-1:0] tag);
        int waited;
        rsp_valid = 1'b1;
        rsp.tag = tag;
        rsp.payload = {next_random(), next_random()};
        rsp_taken = 1'b0;
        waited = 0;
        while (!rsp_taken)
        begin
            if (waited == WAIT_LIMIT)
                report_problem("a response was never accepted");
            advance();
            waited++;
        end
        rsp_valid = 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 || cpl_valid)
        begin
            if (waited == WAIT_LIMIT)
                report_problem("expected completions never left the DUT");
            idle(1);
            waited++;
        end
    endtask

    // Shuffles the first n tags of the list
    task automatic shuffle_tags(input int n);
        logic [31:0] rnd;
        logic [TAG_WIDTH-1:0] swap;
        int j;
        for (int i = n - 1; i > 0; i--)
        begin
            rnd = next_random();
            j = int'(rnd % 32'(i + 1));
            swap = tags[i];
            tags[i] = tags[j];
            tags[j] = swap;
        end
    endtask

    // Optionally starts a new reset and checks the idle state after its release
    task automatic run_reset(input logic restart);
        int waited;
        req_valid = 1'b0;
        rsp_valid = 1'b0;
        cpl_ready = 1'b0;
        reset_request = restart;
        waited = 0;
        while (restart && reset_n)
        begin
            if (waited == WAIT_LIMIT)
                report_problem("reset_n never went low");
            @(negedge clk);
            waited++;
        end
        reset_request = 1'b0;
        waited = 0;
        while (!reset_n)
        begin
            if (waited == WAIT_LIMIT)
                report_problem("reset_n never went high");
            @(negedge clk);
            waited++;
        end
        // Reset clears the active map but leaves the request table as it was
        exp_q.delete();
        model_active = '0;
        model_fill = 0;
        model_stage = 1'b0;
        expect_error = 1'b0;
        held = 1'b0;
        assert (!cpl_valid)
        else report_mismatch("cpl_valid", 128'(1'b0), 128'(cpl_valid));
        assert (!error)
        else report_mismatch("error", 128'(1'b0), 128'(error));
        assert (rsp_ready)
        else report_mismatch("rsp_ready", 128'(1'b1), 128'(rsp_ready));
    endtask

    initial
    begin
        logic [31:0] rnd;
        int count;
        seed = 32'h3a585be7;
        reset_request = 1'b0;
        req_valid = 1'b0;
        req = '0;
        rsp_valid = 1'b0;
        rsp = '0;
        cpl_ready = 1'b0;
        throttle = 1'b0;
        rsp_taken = 1'b0;
        held = 1'b0;
        held_cpl = '0;
        model_active = '0;
        model_fill = 0;
        model_stage = 1'b0;
        expect_error = 1'b0;
        for (int i = 0; i < MAX_OUTSTANDING_RD; i++)
            tags[i] = TAG_WIDTH'(i);
        @(negedge clk);
        run_reset(1'b0);

        // A single read shows its completion one edge after the response is taken
        send_req(5'd3);
        idle(1);
        send_rsp(5'd3);
        assert (!cpl_valid)
        else report_mismatch("cpl_valid", 128'(1'b0), 128'(cpl_valid));
        idle(1);
        assert (cpl_valid)
        else report_mismatch("cpl_valid", 128'(1'b1), 128'(cpl_valid));
        drain();

        // Many tags are outstanding and answered in random order
        // Later rounds stall the consumer
        for (int round = 0; round < 8; round++)
        begin
            throttle = (round >= 3);
            shuffle_tags(MAX_OUTSTANDING_RD);
            rnd = next_random();
            count = 8 + int'(rnd % 32'd25);
            for (int i = 0; i < count; i++)
                send_req(tags[i]);
            // The table write lands one edge after the request
            idle(1);
            shuffle_tags(count);
            for (int i = 0; i < count; i++)
                send_rsp(tags[i]);
            drain();
        end

        // A second request for a tag still outstanding
        throttle = 1'b0;
        send_req(5'd9);
        idle(1);
        send_req(5'd9);
        idle(4);
        assert (error)
        else report_mismatch("error", 128'(1'b1), 128'(error));
        run_reset(1'b1);

        // Response for tag 9, which reset left inactive
        send_rsp(5'd9);
        drain();
        assert (error)
        else report_mismatch("error", 128'(1'b1), 128'(error));
        run_reset(1'b1);

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
src/mmio_cpl_pkg.sv
src/mmio_read_tracker.sv
src/mmio_rsp_fifo.sv
src/mmio_cpl_builder.sv
src/mmio_cpl_top.sv
testbench/tb_clock_gen.sv
testbench/tb_mmio_cpl.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it; a failing run exits non-zero
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f tb.f \
    --top-module tb_mmio_cpl \
    -o tb_mmio_cpl

./obj_dir/tb_mmio_cpl
